// File: ras_stack.f
+incdir+hw
hw/ras_stack_pkg.sv
hw/ras_entry.sv
hw/ras_ptr_ctrl.sv
hw/ras_pred_out.sv
hw/ras_stack_top.sv
testbench/ras_stack_props.sv
testbench/ras_stack_tb.sv

// File: Makefile
# Verilator build for the return address stack testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ras_stack_tb
FILELIST = ras_stack.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator status is ignored here, the log search decides the result
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/ras_stack_tb.sv
/* RAS testbench
   Directed and random push/pop/flush traffic against a reference model */

`timescale 1ns/1ps
`include "ras_stack_config.svh"

module ras_stack_tb;

  localparam int WAIT_LIMIT = 50;

  // DUT ports
  logic                     entry_clk;
  logic                     cpurst_b;
  logic                     push_valid;
  logic                     push_ready;
  ras_stack_pkg::ras_push_t push_data;
  logic                     pop_valid;
  logic                     pop_ready;
  logic                     rsp_valid;
  logic                     rsp_ready;
  ras_stack_pkg::ras_pred_t rsp_data;
  logic                     flush;

  // Reference model, circular stack plus response register
  ras_stack_pkg::ras_pc_t   mdl_mem [`RAS_DEPTH];
  int                       mdl_ptr;
  int                       mdl_cnt;
  logic                     mdl_rsp_valid;
  ras_stack_pkg::ras_pred_t mdl_rsp;

  // Handshakes of the last cycle and consumed responses
  logic                     push_fire_seen;
  logic                     pop_fire_seen;
  ras_stack_pkg::ras_pred_t got_q [$];

  // Random stimulus state, valids held until accepted
  logic [31:0]              rnd_state;
  logic                     rnd_push_v;
  ras_stack_pkg::ras_pc_t   rnd_push_pc;
  logic                     rnd_pop_v;

  ras_stack_top dut_i (
    .entry_clk  (entry_clk ),
    .cpurst_b   (cpurst_b  ),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data ),
    .pop_valid  (pop_valid ),
    .pop_ready  (pop_ready ),
    .rsp_valid  (rsp_valid ),
    .rsp_ready  (rsp_ready ),
    .rsp_data   (rsp_data  ),
    .flush      (flush     )
  );

  initial
  begin
    entry_clk = 1'b0;
    forever #5 entry_clk = ~entry_clk;
  end

  // --------------------
  // Failure reporting
  // --------------------

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] seen,
                             input logic [31:0] expected);
    $display("[FAIL] t=%0t %s seen=0x%0h expected=0x%0h", $time, name, seen, expected);
    abort_run();
  endtask

  task automatic plain_error(input string what);
    $display("t=%0t %s", $time, what);
    abort_run();
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // --------------------
  // One clock cycle
  // --------------------

  // Check registers, drive inputs, check readies, advance the model
  task automatic run_cycle(input logic p_v, input ras_stack_pkg::ras_pc_t p_pc,
                           input logic q_v, input logic f_v, input logic r_v);
    logic                     exp_push_rdy;
    logic                     exp_pop_rdy;
    ras_stack_pkg::ras_pred_t pred;
    @(negedge entry_clk);
    // Registered outputs settled since the rising edge
    assert (rsp_valid === mdl_rsp_valid)
      else value_error("rsp_valid", 32'(rsp_valid), 32'(mdl_rsp_valid));
    if (mdl_rsp_valid)
    begin
      assert (rsp_data === mdl_rsp)
        else value_error("rsp_data", 32'(rsp_data), 32'(mdl_rsp));
      if (r_v)
      begin
        got_q.push_back(rsp_data);
      end
    end
    push_valid   = p_v;
    push_data.pc = p_pc;
    pop_valid    = q_v;
    flush        = f_v;
    rsp_ready    = r_v;
    #1;
    // Flush blocks both, pop blocks push, pop needs a free response slot
    exp_push_rdy = !q_v && !f_v;
    exp_pop_rdy  = (!mdl_rsp_valid || r_v) && !f_v;
    assert (push_ready === exp_push_rdy)
      else value_error("push_ready", 32'(push_ready), 32'(exp_push_rdy));
    assert (pop_ready === exp_pop_rdy)
      else value_error("pop_ready", 32'(pop_ready), 32'(exp_pop_rdy));
    push_fire_seen = p_v && exp_push_rdy;
    pop_fire_seen  = q_v && exp_pop_rdy;
    // Response register
    if (pop_fire_seen)
    begin
      pred.pc       = mdl_mem[(mdl_ptr + `RAS_DEPTH - 1) % `RAS_DEPTH];
      pred.hit      = (mdl_cnt != 0);
      mdl_rsp       = pred;
      mdl_rsp_valid = 1'b1;
    end
    else if (r_v)
    begin
      mdl_rsp_valid = 1'b0;
    end
    // Stack state, pointer kept on flush and on an empty pop
    if (f_v)
    begin
      mdl_cnt = 0;
    end
    else if (pop_fire_seen && mdl_cnt != 0)
    begin
      mdl_ptr = (mdl_ptr + `RAS_DEPTH - 1) % `RAS_DEPTH;
      mdl_cnt--;
    end
    else if (push_fire_seen)
    begin
      mdl_mem[mdl_ptr] = p_pc;
      mdl_ptr = (mdl_ptr + 1) % `RAS_DEPTH;
      if (mdl_cnt < `RAS_DEPTH)
      begin
        mdl_cnt++;
      end
    end
  endtask

  // --------------------
  // Directed helpers
  // --------------------

  task automatic push_pc(input ras_stack_pkg::ras_pc_t pc);
    int waited;
    waited = 0;
    run_cycle(1'b1, pc, 1'b0, 1'b0, 1'b1);
    while (!push_fire_seen)
    begin
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        plain_error("push was never accepted");
      end
      run_cycle(1'b1, pc, 1'b0, 1'b0, 1'b1);
    end
  endtask

  task automatic pop_accept(input logic rdy);
    int waited;
    waited = 0;
    run_cycle(1'b0, '0, 1'b1, 1'b0, rdy);
    while (!pop_fire_seen)
    begin
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        plain_error("pop was never accepted");
      end
      run_cycle(1'b0, '0, 1'b1, 1'b0, rdy);
    end
  endtask

  task automatic wait_responses(input int n);
    int waited;
    waited = 0;
    while (got_q.size() < n)
    begin
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        plain_error("response did not arrive");
      end
      run_cycle(1'b0, '0, 1'b0, 1'b0, 1'b1);
    end
  endtask

  // Miss carries a stale PC, only the flag is compared
  task automatic pop_expect(input logic exp_hit, input ras_stack_pkg::ras_pc_t exp_pc);
    got_q.delete();
    pop_accept(1'b1);
    wait_responses(1);
    assert (got_q[0].hit === exp_hit)
      else value_error("rsp_data.hit", 32'(got_q[0].hit), 32'(exp_hit));
    if (exp_hit)
    begin
      assert (got_q[0].pc === exp_pc)
        else value_error("rsp_data.pc", 32'(got_q[0].pc), 32'(exp_pc));
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial
  begin
    cpurst_b     = 1'b0;
    push_valid   = 1'b0;
    push_data    = '0;
    pop_valid    = 1'b0;
    rsp_ready    = 1'b0;
    flush        = 1'b0;
    mdl_ptr      = 0;
    mdl_cnt      = 0;
    mdl_rsp      = '0;
    mdl_rsp_valid = 1'b0;
    for (int i = 0; i < `RAS_DEPTH; i++)
    begin
      mdl_mem[i] = '0;
    end
    rnd_state  = 32'h9c6a;
    rnd_push_v = 1'b0;
    rnd_push_pc = '0;
    rnd_pop_v  = 1'b0;
    repeat (16) @(posedge entry_clk);
    @(negedge entry_clk);
    cpurst_b = 1'b1;

    // Empty stack after reset
    repeat (3) run_cycle(1'b0, '0, 1'b0, 1'b0, 1'b1);
    pop_expect(1'b0, '0);

    // LIFO order, then one miss
    for (int i = 0; i < 5; i++)
    begin
      push_pc(ras_stack_pkg::ras_pc_t'(32'h100000 + i * 16));
    end
    for (int i = 4; i >= 0; i--)
    begin
      pop_expect(1'b1, ras_stack_pkg::ras_pc_t'(32'h100000 + i * 16));
    end
    pop_expect(1'b0, '0);

    // Overflow drops the oldest three
    for (int i = 0; i < `RAS_DEPTH + 3; i++)
    begin
      push_pc(ras_stack_pkg::ras_pc_t'(32'h300000 + i * 4));
    end
    for (int i = `RAS_DEPTH + 2; i >= 3; i--)
    begin
      pop_expect(1'b1, ras_stack_pkg::ras_pc_t'(32'h300000 + i * 4));
    end
    pop_expect(1'b0, '0);

    // Flush then refill
    push_pc(ras_stack_pkg::ras_pc_t'(32'h400010));
    push_pc(ras_stack_pkg::ras_pc_t'(32'h400020));
    run_cycle(1'b0, '0, 1'b0, 1'b1, 1'b1);
    pop_expect(1'b0, '0);
    push_pc(ras_stack_pkg::ras_pc_t'(32'h400030));
    push_pc(ras_stack_pkg::ras_pc_t'(32'h400040));
    pop_expect(1'b1, ras_stack_pkg::ras_pc_t'(32'h400040));
    pop_expect(1'b1, ras_stack_pkg::ras_pc_t'(32'h400030));

    // Back-pressure on the response channel
    push_pc(ras_stack_pkg::ras_pc_t'(32'h500010));
    push_pc(ras_stack_pkg::ras_pc_t'(32'h500020));
    push_pc(ras_stack_pkg::ras_pc_t'(32'h500030));
    got_q.delete();
    pop_accept(1'b0);
    // Pending pop stalls, push blocked behind it
    repeat (4) run_cycle(1'b0, '0, 1'b1, 1'b0, 1'b0);
    pop_accept(1'b1);
    wait_responses(2);
    assert (got_q[0].pc === ras_stack_pkg::ras_pc_t'(32'h500030))
      else value_error("rsp_data.pc", 32'(got_q[0].pc), 32'h500030);
    assert (got_q[1].pc === ras_stack_pkg::ras_pc_t'(32'h500020))
      else value_error("rsp_data.pc", 32'(got_q[1].pc), 32'h500020);

    // Random mix
    for (int n = 0; n < 400; n++)
    begin
      rnd_state = lcg_next(rnd_state);
      if (!rnd_push_v)
      begin
        rnd_push_v  = rnd_state[20];
        rnd_push_pc = ras_stack_pkg::ras_pc_t'(rnd_state >> 8);
      end
      if (!rnd_pop_v)
      begin
        rnd_pop_v = rnd_state[21] & rnd_state[22];
      end
      run_cycle(rnd_push_v, rnd_push_pc, rnd_pop_v, rnd_state[27:24] == 4'h0,
                rnd_state[28] | rnd_state[29]);
      if (push_fire_seen)
      begin
        rnd_push_v = 1'b0;
      end
      if (pop_fire_seen)
      begin
        rnd_pop_v = 1'b0;
      end
    end
    repeat (4) run_cycle(1'b0, '0, 1'b0, 1'b0, 1'b1);

    // Bound properties count their own failures
    if (dut_i.u_props.fail_cnt == 0)
    begin
      $display("TB PASSED");
      $finish;
    end
    else
    begin
      plain_error("bound handshake property failed");
    end
  end

endmodule

// File: testbench/ras_stack_props.sv
/* RAS handshake properties
   Reset, hold and arbitration checks bound to the stack top */

`timescale 1ns/1ps

module ras_stack_props (
  input logic                     entry_clk,
  input logic                     cpurst_b,
  input logic                     pop_valid,
  input logic                     pop_ready,
  input logic                     push_ready,
  input logic                     rsp_valid,
  input logic                     rsp_ready,
  input ras_stack_pkg::ras_pred_t rsp_data
);

  // Failed property count, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // No response while in reset
  assert property (@(posedge entry_clk) !cpurst_b |-> !rsp_valid)
    else
    begin
      fail_cnt++;
      $error("rsp_valid high during reset");
    end

  // Stalled response keeps its payload
  assert property (@(posedge entry_clk) disable iff (!cpurst_b)
                   (rsp_valid && !rsp_ready) |=> $stable(rsp_data))
    else
    begin
      fail_cnt++;
      $error("rsp_data changed while stalled");
    end

  // Pop always wins over push
  assert property (@(posedge entry_clk) disable iff (!cpurst_b)
                   pop_valid |-> !push_ready)
    else
    begin
      fail_cnt++;
      $error("push_ready high with pop_valid");
    end

  // Response one cycle after the accepted pop
  assert property (@(posedge entry_clk) disable iff (!cpurst_b)
                   (pop_valid && pop_ready) |=> rsp_valid)
    else
    begin
      fail_cnt++;
      $error("no response after accepted pop");
    end

endmodule

bind ras_stack_top ras_stack_props u_props (
  .entry_clk  (entry_clk ),
  .cpurst_b   (cpurst_b  ),
  .pop_valid  (pop_valid ),
  .pop_ready  (pop_ready ),
  .push_ready (push_ready),
  .rsp_valid  (rsp_valid ),
  .rsp_ready  (rsp_ready ),
  .rsp_data   (rsp_data  )
);

// File: hw/ras_stack_top.sv
/* Return address stack top
   Pointer control, entry array and response stage */

`timescale 1ns/1ps
`include "ras_stack_config.svh"

module ras_stack_top (
  input  logic                     entry_clk,
  input  logic                     cpurst_b,
  // Push channel
  input  logic                     push_valid,
  output logic                     push_ready,
  input  ras_stack_pkg::ras_push_t push_data,
  // Pop channel
  input  logic                     pop_valid,
  output logic                     pop_ready,
  // Response channel
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output ras_stack_pkg::ras_pred_t rsp_data,
  // Empties the stack
  input  logic                     flush
);

  // Entry write path
  ras_stack_pkg::ras_upd_t      entry_upd;
  ras_stack_pkg::ras_pc_t       upd_pc;
  // Entry read path
  ras_stack_pkg::ras_pc_array_t entry_pcs;
  logic                         pop_fire;
  ras_stack_pkg::ras_ptr_t      rd_idx;
  logic                         rd_hit;
  // Response register has room
  logic                         rsp_free;

  // --------------------
  // Pointer control
  // --------------------

  ras_ptr_ctrl u_ptr_ctrl (
    .entry_clk  (entry_clk ),
    .cpurst_b   (cpurst_b  ),
    .push_valid (push_valid),
    .push_data  (push_data ),
    .pop_valid  (pop_valid ),
    .flush      (flush     ),
    .rsp_free   (rsp_free  ),
    .push_ready (push_ready),
    .pop_ready  (pop_ready ),
    .entry_upd  (entry_upd ),
    .upd_pc     (upd_pc    ),
    .pop_fire   (pop_fire  ),
    .rd_idx     (rd_idx    ),
    .rd_hit     (rd_hit    )
  );

  // --------------------
  // Entry array
  // --------------------

  // One gated slot per depth step
  for (genvar i = 0; i < `RAS_DEPTH; i++)
  begin : u_entry
    ras_entry u_entry (
      .entry_clk     (entry_clk   ),
      .cpurst_b      (cpurst_b    ),
      .ras_entry_upd (entry_upd[i]),
      .ras_upd_pc    (upd_pc      ),
      .ras_entry_pc  (entry_pcs[i])
    );
  end

  // --------------------
  // Response stage
  // --------------------

  ras_pred_out u_pred_out (
    .entry_clk (entry_clk),
    .cpurst_b  (cpurst_b ),
    .entry_pcs (entry_pcs),
    .pop_fire  (pop_fire ),
    .rd_idx    (rd_idx   ),
    .rd_hit    (rd_hit   ),
    .rsp_ready (rsp_ready),
    .rsp_free  (rsp_free ),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data )
  );

endmodule

// File: hw/ras_pred_out.sv
/* RAS prediction output
   Selects the popped entry and holds it in a valid/ready response register */

`timescale 1ns/1ps

module ras_pred_out (
  input  logic                         entry_clk,
  input  logic                         cpurst_b,
  input  ras_stack_pkg::ras_pc_array_t entry_pcs,
  input  logic                         pop_fire,
  input  ras_stack_pkg::ras_ptr_t      rd_idx,
  input  logic                         rd_hit,
  input  logic                         rsp_ready,
  output logic                         rsp_free,
  output logic                         rsp_valid,
  output ras_stack_pkg::ras_pred_t     rsp_data
);

  // Entry PC named by the read index
  ras_stack_pkg::ras_pc_t   sel_pc;
  // Prediction about to be loaded
  ras_stack_pkg::ras_pred_t pred_nxt;

  // --------------------
  // Entry select
  // --------------------

  // Read mux over the whole array
  assign sel_pc = entry_pcs[rd_idx];

  // Miss still carries the selected PC, only the flag drops
  always_comb
  begin
    pred_nxt.pc  = sel_pc;
    pred_nxt.hit = rd_hit;
  end

  // --------------------
  // Response register
  // --------------------

  // Room for a new pop when empty or draining now
  assign rsp_free = ~rsp_valid | rsp_ready;

  // Valid flag
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rsp_valid <= 1'b0;
    end
    else if (pop_fire)
    begin
      rsp_valid <= 1'b1;
    end
    else if (rsp_ready)
    begin
      rsp_valid <= 1'b0;
    end
  end

  // Payload, loaded only on an accepted pop
  // pop_fire implies rsp_free so a held response is never overwritten
  always_ff @(posedge entry_clk)
  begin
    if (pop_fire)
    begin
      rsp_data <= pred_nxt;
    end
  end

endmodule

// File: hw/ras_ptr_ctrl.sv
/* RAS pointer control
   Top pointer and count, flush/pop/push arbitration, entry strobes */

`timescale 1ns/1ps
`include "ras_stack_config.svh"

module ras_ptr_ctrl (
  input  logic                     entry_clk,
  input  logic                     cpurst_b,
  input  logic                     push_valid,
  input  ras_stack_pkg::ras_push_t push_data,
  input  logic                     pop_valid,
  input  logic                     flush,
  input  logic                     rsp_free,
  output logic                     push_ready,
  output logic                     pop_ready,
  output ras_stack_pkg::ras_upd_t  entry_upd,
  output ras_stack_pkg::ras_pc_t   upd_pc,
  output logic                     pop_fire,
  output ras_stack_pkg::ras_ptr_t  rd_idx,
  output logic                     rd_hit
);

  // Next slot to write
  ras_stack_pkg::ras_ptr_t top_ptr;
  // Valid entries held
  ras_stack_pkg::ras_cnt_t entry_cnt;
  // Accepted push this cycle
  logic                    push_fire;
  // Stack state flags
  logic                    stack_empty;
  logic                    stack_full;

  // --------------------
  // Status
  // --------------------

  assign stack_empty = (entry_cnt == '0);
  // Full count saturates, further pushes overwrite the oldest
  assign stack_full  = (entry_cnt == ras_stack_pkg::ras_cnt_t'(`RAS_DEPTH));

  // --------------------
  // Arbitration
  // --------------------

  // Flush first, accepts neither channel
  // Pop needs room in the response register
  assign pop_ready  = rsp_free & ~flush;
  // Any pending pop blocks the push
  assign push_ready = ~pop_valid & ~flush;

  assign pop_fire  = pop_valid & pop_ready;
  assign push_fire = push_valid & push_ready;

  // --------------------
  // Entry write
  // --------------------

  // One-hot strobe for the slot at the pointer
  always_comb
  begin
    entry_upd = '0;
    if (push_fire)
    begin
      entry_upd[top_ptr] = 1'b1;
    end
  end

  // Same PC goes to every slot, strobe picks the target
  assign upd_pc = push_data.pc;

  // --------------------
  // Read side
  // --------------------

  // Newest entry sits just below the pointer
  // Wraps around on its own with a power of two depth
  assign rd_idx = top_ptr - 1'b1;
  // Empty stack gives a miss
  assign rd_hit = ~stack_empty;

  // --------------------
  // Pointer and count
  // --------------------

  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      top_ptr   <= '0;
      entry_cnt <= '0;
    end
    else if (flush)
    begin
      // Count only, pointer left where it is
      entry_cnt <= '0;
    end
    else if (pop_fire)
    begin
      // Miss on empty leaves state untouched
      if (!stack_empty)
      begin
        top_ptr   <= top_ptr - 1'b1;
        entry_cnt <= entry_cnt - 1'b1;
      end
    end
    else if (push_fire)
    begin
      top_ptr <= top_ptr + 1'b1;
      if (!stack_full)
      begin
        entry_cnt <= entry_cnt + 1'b1;
      end
    end
  end

endmodule

// File: hw/ras_entry.sv
/* RAS entry
   One stack slot, a PC register behind a latch-based clock gate */

`timescale 1ns/1ps

module ras_entry (
  input  logic                   entry_clk,
  input  logic                   cpurst_b,
  input  logic                   ras_entry_upd,
  input  ras_stack_pkg::ras_pc_t ras_upd_pc,
  output ras_stack_pkg::ras_pc_t ras_entry_pc
);

  // Latched enable and the gated clock it produces
  logic                   clk_en_lat;
  logic                   gated_clk;
  // Stored return PC
  ras_stack_pkg::ras_pc_t entry_pc;

  // --------------------
  // Clock gate
  // --------------------

  // Enable sampled while the clock is low
  // Closes on the rising edge so no glitch reaches gated_clk
  always_latch
  begin
    if (!entry_clk)
    begin
      clk_en_lat = ras_entry_upd;
    end
  end

  // Idle slot sees no clock edges
  assign gated_clk = entry_clk & clk_en_lat;

  // --------------------
  // Entry PC
  // --------------------

  // Every gated edge is an update
  // The gate already restricts edges to strobe cycles
  always_ff @(posedge gated_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_pc <= '0;
    end
    else
    begin
      entry_pc <= ras_upd_pc;
    end
  end

  // Stored PC straight out to the read mux
  assign ras_entry_pc = entry_pc;

endmodule

// File: hw/ras_stack_pkg.sv
/* Return address stack types
   Vector typedefs and channel payload structs */

`include "ras_stack_config.svh"

package ras_stack_pkg;

  // Return PC
  typedef logic [`RAS_PC_WIDTH-1:0] ras_pc_t;

  // Entry index
  typedef logic [`RAS_PTR_W-1:0] ras_ptr_t;

  // Occupancy, 0 up to the full depth
  typedef logic [`RAS_PTR_W:0] ras_cnt_t;

  // One update strobe per entry
  typedef logic [`RAS_DEPTH-1:0] ras_upd_t;

  // Push payload
  typedef struct packed {
    ras_pc_t pc;
  } ras_push_t;

  // Response payload, predicted target plus hit flag
  typedef struct packed {
    ras_pc_t pc;
    logic    hit;
  } ras_pred_t;

  // All entry PCs side by side
  typedef ras_pc_t [`RAS_DEPTH-1:0] ras_pc_array_t;

endpackage

// File: hw/ras_stack_config.svh
/* Return address stack configuration
   Widths and depth shared by the RAS package and RTL */

`ifndef RAS_STACK_CONFIG_SVH
`define RAS_STACK_CONFIG_SVH

// Width of a stored return PC
`define RAS_PC_WIDTH 24

// Number of stack entries, power of two
`define RAS_DEPTH 8

// Index width, log2 of the depth
`define RAS_PTR_W 3

`endif
